/* design/vic_pkg.sv */
`default_nettype none

package vic_pkg;

  // widths that carry a meaning
  typedef logic [3:0] phase_t;    // tick within a bus cycle
  typedef logic [5:0] cycle_t;    // bus cycle within a raster line
  typedef logic [8:0] line_t;     // raster line
  typedef logic [5:0] reg_addr_t; // register select from adl
  typedef logic [7:0] bus_data_t; // data bus byte
  typedef logic [3:0] colour_t;   // palette index

  // bus cycle timing, clk_phi low on ticks 0..7 and high on 8..15
  localparam int     TICKS_PER_PHI   = 16;
  localparam phase_t PHI_LAST_TICK   = phase_t'(TICKS_PER_PHI - 1);
  localparam phase_t CPU_SAMPLE_TICK = 4'd12; // write capture
  localparam phase_t READ_DRIVE_TICK = 4'd10; // first tick on dbl
  localparam phase_t DRIVE_ARM_TICK  = READ_DRIVE_TICK - 4'd1; // drive flop loads here

  // PAL raster geometry
  localparam cycle_t CYCLES_PER_LINE = 6'd63;
  localparam cycle_t LAST_CYCLE      = CYCLES_PER_LINE - 6'd1;
  localparam line_t  LINES_PER_FRAME = 9'd312;
  localparam line_t  LAST_LINE       = LINES_PER_FRAME - 9'd1;
  localparam cycle_t HSYNC_CYCLES    = 6'd4;  // sync at line start
  localparam line_t  VSYNC_LINES     = 9'd3;  // sync at frame start

  // register map
  localparam reg_addr_t REG_CTRL   = 6'h11; // bit 7 is raster bit 8
  localparam reg_addr_t REG_RASTER = 6'h12;
  localparam reg_addr_t REG_LPX    = 6'h13;
  localparam reg_addr_t REG_LPY    = 6'h14;
  localparam reg_addr_t REG_IRQ    = 6'h19; // status, write 1 to clear
  localparam reg_addr_t REG_IRQ_EN = 6'h1A;
  localparam reg_addr_t REG_BORDER = 6'h20;
  localparam reg_addr_t REG_BG0    = 6'h21;

  // interrupt sources, only raster and light pen exist here
  localparam int IRQ_BITS   = 4;
  localparam int IRQ_RASTER = 0;
  localparam int IRQ_LPEN   = 3;

  // filler for read bits that have no storage
  localparam bus_data_t UNMAPPED_READ = 8'hFF;

endpackage

`default_nettype wire

/* design/phase_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_gen (
  input  logic            clk_col4x_pal,
  input  logic            rst_n,
  output vic_pkg::phase_t phase,   // tick 0..15 within the bus cycle
  output logic            phi_end, // last tick of the bus cycle
  output logic            clk_phi  // cpu clock pin
);

  vic_pkg::phase_t phase_nxt;

  // free running tick counter
  always_comb begin
    if (phase == vic_pkg::PHI_LAST_TICK) begin
      phase_nxt = '0; // wrap into next bus cycle
    end else begin
      phase_nxt = phase + 4'd1;
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      phase <= '0; // first clock out of reset is tick 0
    end else begin
      phase <= phase_nxt;
    end
  end

  // clk_phi comes straight off a flop so the pin never glitches
  // loading from phase_nxt keeps it aligned with the tick count,
  // low for the first half and high for the second
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      clk_phi <= 1'b0;
    end else begin
      clk_phi <= phase_nxt[3];
    end
  end

  // strobe that advances the raster counters
  assign phi_end = (phase == vic_pkg::PHI_LAST_TICK);

endmodule

`default_nettype wire

/* design/raster_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timer (
  input  logic            clk_col4x_pal,
  input  logic            rst_n,
  input  logic            phi_end,      // one clock per bus cycle
  output vic_pkg::cycle_t raster_cycle, // 0..62
  output vic_pkg::line_t  raster_line,  // 0..311
  output logic            line_start,   // first tick of cycle 0
  output logic            frame_start,  // first tick of line 0
  output logic            hsync,        // active low
  output logic            vsync         // active low
);

  vic_pkg::cycle_t cycle_nxt;
  vic_pkg::line_t  line_nxt;
  logic            line_end;  // last tick of last cycle in line
  logic            frame_end; // last tick of last line

  assign line_end  = phi_end && (raster_cycle == vic_pkg::LAST_CYCLE);
  assign frame_end = line_end && (raster_line == vic_pkg::LAST_LINE);

  // nested counters, line steps when the cycle wraps
  always_comb begin
    cycle_nxt = raster_cycle;
    line_nxt  = raster_line;
    if (phi_end) begin
      if (line_end) begin
        cycle_nxt = '0;
        if (frame_end) begin
          line_nxt = '0; // back to top of frame
        end else begin
          line_nxt = raster_line + 9'd1;
        end
      end else begin
        cycle_nxt = raster_cycle + 6'd1;
      end
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      raster_cycle <= '0;
      raster_line  <= '0;
    end else begin
      raster_cycle <= cycle_nxt;
      raster_line  <= line_nxt;
    end
  end

  // strobes and syncs are registered alongside the counters,
  // so they line up with the position they describe
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      line_start  <= 1'b0;
      frame_start <= 1'b0;
      hsync       <= 1'b0; // reset position is cycle 0 of line 0
      vsync       <= 1'b0;
    end else begin
      line_start  <= line_end;
      frame_start <= frame_end;
      hsync       <= !(cycle_nxt < vic_pkg::HSYNC_CYCLES); // low for cycles 0..3
      vsync       <= !(line_nxt < vic_pkg::VSYNC_LINES);   // low for lines 0..2
    end
  end

endmodule

`default_nettype wire

/* design/cpu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_regs (
  input  logic                 clk_col4x_pal,
  input  logic                 rst_n,
  input  vic_pkg::phase_t      phase,
  input  vic_pkg::cycle_t      raster_cycle,
  input  vic_pkg::line_t       raster_line,
  input  logic                 line_start,
  input  logic                 frame_start,
  input  logic                 ce,             // chip select, low active
  input  logic                 rw,             // high = cpu read
  input  logic                 lp,             // light pen, falling edge
  input  vic_pkg::reg_addr_t   adi,
  input  vic_pkg::bus_data_t   dbi,
  output vic_pkg::bus_data_t   dbo,
  output logic                 vic_write_db,   // enables dbl drive at the top
  output logic                 ls245_data_dir, // high = chip toward cpu
  output logic                 irq,            // low active
  output vic_pkg::colour_t     border_colour,
  output vic_pkg::colour_t     bg_colour
);

  vic_pkg::line_t                raster_cmp; // compare value, 9 bits
  logic [6:0]                    ctrl_lo;    // rest of ctrl, kept as written
  logic [vic_pkg::IRQ_BITS-1:0]  irq_status;
  logic [vic_pkg::IRQ_BITS-1:0]  irq_en;
  logic [vic_pkg::IRQ_BITS-1:0]  irq_set;
  logic [vic_pkg::IRQ_BITS-1:0]  irq_clr;
  vic_pkg::bus_data_t            lpx;
  vic_pkg::bus_data_t            lpy;
  vic_pkg::bus_data_t            rd_data;
  logic                          lp_s;       // lp sample
  logic                          lp_d;       // previous sample
  logic                          lp_done;    // latch used this frame
  logic                          lp_take;
  logic                          wr_stb;
  logic                          rd_win;
  logic                          raster_hit;
  logic                          irq_any;
  logic                          drive_q;

  // access decode, all inside the clk_phi high half
  assign wr_stb = !ce && !rw && (phase == vic_pkg::CPU_SAMPLE_TICK);
  // drive flop loads on ticks 9..14, so dbl is driven on 10..15
  assign rd_win = !ce && rw && (phase >= vic_pkg::DRIVE_ARM_TICK) &&
                  (phase != vic_pkg::PHI_LAST_TICK);

  assign raster_hit = line_start && (raster_line == raster_cmp); // new line already counted
  assign lp_take    = lp_d && !lp_s && !lp_done;                 // first falling edge only
  assign irq_any    = |(irq_status & irq_en);

  always_comb begin
    irq_set                      = '0;
    irq_set[vic_pkg::IRQ_RASTER] = raster_hit;
    irq_set[vic_pkg::IRQ_LPEN]   = lp_take;
  end

  // write 1 to clear
  assign irq_clr = (wr_stb && (adi == vic_pkg::REG_IRQ)) ? dbi[vic_pkg::IRQ_BITS-1:0] : '0;

  // cpu writable registers
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      raster_cmp    <= '0;
      ctrl_lo       <= '0;
      irq_en        <= '0;
      border_colour <= '0;
      bg_colour     <= '0;
    end else if (wr_stb) begin
      case (adi)
        vic_pkg::REG_CTRL: begin
          raster_cmp[8] <= dbi[7]; // compare msb lives here
          ctrl_lo       <= dbi[6:0];
        end
        vic_pkg::REG_RASTER: raster_cmp[7:0] <= dbi;
        vic_pkg::REG_IRQ_EN: irq_en <= dbi[vic_pkg::IRQ_BITS-1:0];
        vic_pkg::REG_BORDER: border_colour <= dbi[3:0];
        vic_pkg::REG_BG0:    bg_colour <= dbi[3:0];
        default: ;           // status handled below, rest read only
      endcase
    end
  end

  // status bits, a new event wins over a clear on the same clock
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      irq_status <= '0;
      irq        <= 1'b1;
    end else begin
      irq_status <= (irq_status & ~irq_clr) | irq_set;
      irq        <= !irq_any; // follows status one clock later
    end
  end

  // light pen, sampled every clock, one latch per frame
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      lp_s    <= 1'b1; // idle high so reset gives no edge
      lp_d    <= 1'b1;
      lp_done <= 1'b0;
      lpx     <= '0;
      lpy     <= '0;
    end else begin
      lp_s <= lp;
      lp_d <= lp_s;
      if (frame_start) begin
        lp_done <= 1'b0; // re-arm at top of frame
      end else if (lp_take) begin
        lp_done <= 1'b1;
      end
      if (lp_take) begin
        lpx <= {raster_cycle, 2'b00}; // cycle * 4, max 248
        lpy <= raster_line[7:0];
      end
    end
  end

  // read data, unused bits come back as 1
  always_comb begin
    case (adi)
      vic_pkg::REG_CTRL:   rd_data = {raster_line[8], ctrl_lo};
      vic_pkg::REG_RASTER: rd_data = raster_line[7:0];
      vic_pkg::REG_LPX:    rd_data = lpx;
      vic_pkg::REG_LPY:    rd_data = lpy;
      vic_pkg::REG_IRQ:    rd_data = {irq_any, 3'b111, irq_status};
      vic_pkg::REG_IRQ_EN: rd_data = {4'hF, irq_en};
      vic_pkg::REG_BORDER: rd_data = {4'hF, border_colour};
      vic_pkg::REG_BG0:    rd_data = {4'hF, bg_colour};
      default:             rd_data = vic_pkg::UNMAPPED_READ;
    endcase
  end

  // bus drive, data and transceiver direction switch together
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      drive_q <= 1'b0;
    end else begin
      drive_q <= rd_win;
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    dbo <= rd_data; // one clock behind the mux, settled before tick 10
  end

  assign vic_write_db   = drive_q;
  assign ls245_data_dir = drive_q; // low keeps the transceiver pointing at the chip

endmodule

`default_nettype wire

/* design/vic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_top (
  input  logic             clk_col4x_pal,
  input  logic             rst_n,
  input  logic             ce,             // chip select from the cpu side
  input  logic             rw,             // high = read
  input  logic             lp,             // light pen
  input  logic [5:0]       adl,            // low address lines, input only here
  output tri   [5:0]       adh,            // never mastered in this build
  inout  tri   [7:0]       dbl,            // shared data bus
  output logic             clk_phi,
  output logic             irq,
  output logic             hsync,
  output logic             vsync,
  output logic             ls245_data_dir,
  output logic             ls245_addr_dir,
  output vic_pkg::colour_t border_colour,
  output vic_pkg::colour_t bg_colour
);

  vic_pkg::phase_t    phase;
  logic               phi_end;
  vic_pkg::cycle_t    raster_cycle;
  vic_pkg::line_t     raster_line;
  logic               line_start;
  logic               frame_start;
  vic_pkg::bus_data_t dbo;
  logic               vic_write_db;

  phase_gen u_phase_gen (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .phase         (phase),
    .phi_end       (phi_end),
    .clk_phi       (clk_phi)
  );

  raster_timer u_raster_timer (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .phi_end       (phi_end),
    .raster_cycle  (raster_cycle),
    .raster_line   (raster_line),
    .line_start    (line_start),
    .frame_start   (frame_start),
    .hsync         (hsync),
    .vsync         (vsync)
  );

  cpu_regs u_cpu_regs (
    .clk_col4x_pal  (clk_col4x_pal),
    .rst_n          (rst_n),
    .phase          (phase),
    .raster_cycle   (raster_cycle),
    .raster_line    (raster_line),
    .line_start     (line_start),
    .frame_start    (frame_start),
    .ce             (ce),
    .rw             (rw),
    .lp             (lp),
    .adi            (adl),
    .dbi            (dbl),         // bus is read back even while we drive it
    .dbo            (dbo),
    .vic_write_db   (vic_write_db),
    .ls245_data_dir (ls245_data_dir),
    .irq            (irq),
    .border_colour  (border_colour),
    .bg_colour      (bg_colour)
  );

  // data bus only driven during cpu reads
  assign dbl = vic_write_db ? dbo : 8'bzzzz_zzzz;

  // no address mastering, keep high addr floating and the transceiver inbound
  assign adh            = 6'bzz_zzzz;
  assign ls245_addr_dir = 1'b0;

endmodule

`default_nettype wire

/* tests/tb_vic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vic_top;

  // bus and raster geometry
  localparam int TICKS       = 16;
  localparam int CYCLES      = 63;
  localparam int LINES       = 312;
  localparam int LINE_CLKS   = TICKS * CYCLES;   // 1008 clocks per line
  localparam int FRAME_CLKS  = LINE_CLKS * LINES;
  localparam int MAX_RECS    = 128;
  localparam int MARGIN_CLKS = 4096;             // slack on top of the worst case

  // pattern opcodes
  localparam int OP_END       = 0;
  localparam int OP_WRITE     = 1;
  localparam int OP_READ      = 2;
  localparam int OP_WAIT_LINE = 3;
  localparam int OP_LPEN      = 4;
  localparam int OP_PIN       = 5;
  localparam int OP_IDLE      = 6;

  logic       clk_col4x_pal;
  logic       rst_n;
  logic       ce;
  logic       rw;
  logic       lp;
  logic [5:0] adl;
  logic [7:0] db_drv;     // cpu side data
  logic       db_drv_en;  // only on write cycles
  tri1  [5:0] adh;        // pull-up so a floating address bus reads high
  tri1  [7:0] dbl;        // pull-up on the shared data bus
  wire        clk_phi;
  wire        irq;
  wire        hsync;
  wire        vsync;
  wire        ls245_data_dir;
  wire        ls245_addr_dir;
  wire  [3:0] border_colour;
  wire  [3:0] bg_colour;

  logic [39:0] pat_mem [MAX_RECS]; // op_addr_wdata_expect_mask
  int          clk_cnt = 0;        // clocks since reset release so tick 0 of line 0 is 0
  int          run_clks = 0;
  int          timeout_clks;
  int          err_count;
  int          check_count;
  integer      seed;
  int          lp_frame;           // frame of the last latching pen edge
  int          lp_line;
  int          lp_cycle;

  assign dbl = db_drv_en ? db_drv : 8'hzz;

  vic_top uut (
    .clk_col4x_pal  (clk_col4x_pal),
    .rst_n          (rst_n),
    .ce             (ce),
    .rw             (rw),
    .lp             (lp),
    .adl            (adl),
    .adh            (adh),
    .dbl            (dbl),
    .clk_phi        (clk_phi),
    .irq            (irq),
    .hsync          (hsync),
    .vsync          (vsync),
    .ls245_data_dir (ls245_data_dir),
    .ls245_addr_dir (ls245_addr_dir),
    .border_colour  (border_colour),
    .bg_colour      (bg_colour)
  );

  initial begin
    clk_col4x_pal = 1'b0;
    forever #4 clk_col4x_pal = ~clk_col4x_pal; // 8 ns period
  end

  // raster reference count and run limit
  always @(posedge clk_col4x_pal) begin
    run_clks <= run_clks + 1;
    if (rst_n) clk_cnt <= clk_cnt + 1;
    if (run_clks > timeout_clks) begin
      $display("timeout: pattern list still running after %0d clocks", run_clks);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic int tick_at(input int c);
    return c % TICKS;
  endfunction

  function automatic int cycle_at(input int c);
    return (c / TICKS) % CYCLES;
  endfunction

  function automatic int line_at(input int c);
    return (c / LINE_CLKS) % LINES;
  endfunction

  function automatic int frame_at(input int c);
    return c / FRAME_CLKS;
  endfunction

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected, input logic [7:0] mask);
    check_count++;
    if ((actual & mask) !== (expected & mask)) begin
      err_count++;
      $display("FAIL %s: got %h expected %h mask %h at clock %0d",
               name, actual, expected, mask, clk_cnt);
    end
  endtask

  // next falling edge that sits inside the given tick
  task automatic wait_tick(input int t);
    @(negedge clk_col4x_pal);
    while (tick_at(clk_cnt) != t) @(negedge clk_col4x_pal);
  endtask

  task automatic check_timing();
    check_value("clk_phi", 8'(clk_phi), 8'(tick_at(clk_cnt) >= 8), 8'h01); // high on ticks 8..15
    check_value("hsync", 8'(hsync), 8'(cycle_at(clk_cnt) >= 4), 8'h01); // low on cycles 0..3
    check_value("vsync", 8'(vsync), 8'(line_at(clk_cnt) >= 3), 8'h01);  // low on lines 0..2
  endtask

  task automatic run_record(input logic [39:0] rec);
    int         op;
    int         target;
    int         lp_clk;
    logic [7:0] wdata;
    logic [7:0] exp_v;
    logic [7:0] mask;
    op     = int'(rec[39:32]);
    wdata  = rec[23:16];
    exp_v  = rec[15:8];
    mask   = rec[7:0];
    target = int'({rec[24], wdata}); // 9-bit line for waits
    case (op)
      OP_WAIT_LINE: begin
        while (!((clk_cnt % LINE_CLKS == 0) && (line_at(clk_cnt) == target)))
          @(negedge clk_col4x_pal);
      end
      OP_LPEN: begin
        wait_tick(2);
        lp     = 1'b0;
        lp_clk = clk_cnt + 1; // pen input is registered once before the edge detect
        if (frame_at(lp_clk) != lp_frame) begin // first edge of a frame latches
          lp_frame = frame_at(lp_clk);
          lp_line  = line_at(lp_clk);
          lp_cycle = cycle_at(lp_clk);
        end
        repeat (6) @(negedge clk_col4x_pal);
        lp = 1'b1;
        wait_tick(0);
      end
      OP_WRITE, OP_READ, OP_PIN, OP_IDLE: begin
        wait_tick(7); // bus settles before clk_phi rises
        check_timing();
        if (op == OP_WRITE || op == OP_READ) begin
          ce        = 1'b0;
          rw        = (op == OP_READ);
          adl       = rec[29:24];
          db_drv    = wdata;
          db_drv_en = (op == OP_WRITE);
        end
        wait_tick(14);
        check_timing();
        case (op)
          OP_WRITE: begin
            check_value("dbl", dbl, wdata, 8'hFF); // chip must not fight the cpu
            check_value("ls245_data_dir", 8'(ls245_data_dir), 8'h00, 8'h01);
          end
          OP_READ: begin
            case (int'(wdata)) // source of the expected value
              1:       exp_v = 8'(line_at(clk_cnt));
              2:       exp_v = 8'((line_at(clk_cnt) >> 8) << 7);
              3:       exp_v = 8'(lp_line);
              4:       exp_v = 8'(lp_cycle * 4);
              default: exp_v = rec[15:8];
            endcase
            check_value($sformatf("dbl read %h", rec[29:24]), dbl, exp_v, mask);
            check_value("ls245_data_dir", 8'(ls245_data_dir), 8'h01, 8'h01);
          end
          OP_PIN: begin
            case (rec[31:24])
              8'h00:   check_value("irq", 8'(irq), exp_v, mask);
              8'h01:   check_value("border_colour", 8'(border_colour), exp_v, mask);
              default: check_value("bg_colour", 8'(bg_colour), exp_v, mask);
            endcase
          end
          default: begin
            check_value("dbl idle", dbl, exp_v, mask); // pull-up only
            check_value("adh", 8'(adh), 8'h3F, 8'h3F);  // never driven by the chip
            check_value("ls245_data_dir", 8'(ls245_data_dir), 8'h00, 8'h01);
            check_value("ls245_addr_dir", 8'(ls245_addr_dir), 8'h00, 8'h01);
          end
        endcase
        wait_tick(0); // hold through tick 15
        ce        = 1'b1;
        rw        = 1'b1;
        db_drv_en = 1'b0;
      end
      default: begin
        err_count++;
        $display("pattern file holds an unknown opcode %0d", op);
      end
    endcase
  endtask

  initial begin
    int gap;
    seed        = 97;
    err_count   = 0;
    check_count = 0;
    lp_frame    = -1;
    lp_line     = 0;
    lp_cycle    = 0;
    rst_n       = 1'b0;
    ce          = 1'b1;
    rw          = 1'b1;
    lp          = 1'b1;
    adl         = '0;
    db_drv      = '0;
    db_drv_en   = 1'b0;
    for (int i = 0; i < MAX_RECS; i++) pat_mem[i] = '0;
    $readmemh("tests/vic_patterns.txt", pat_mem);
    // worst case is a full frame per line wait and six bus cycles per other record
    timeout_clks = MARGIN_CLKS + 8;
    for (int i = 0; i < MAX_RECS; i++) begin
      if (int'(pat_mem[i][39:32]) == OP_END) break;
      if (int'(pat_mem[i][39:32]) == OP_WAIT_LINE) timeout_clks += FRAME_CLKS;
      else timeout_clks += 6 * TICKS;
    end
    repeat (8) @(negedge clk_col4x_pal);
    rst_n = 1'b1;
    for (int i = 0; i < MAX_RECS; i++) begin
      if (int'(pat_mem[i][39:32]) == OP_END) break;
      gap = int'($unsigned($random(seed)) % 4); // idle bus cycles
      repeat (gap * TICKS) @(negedge clk_col4x_pal);
      run_record(pat_mem[i]);
    end
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/vic_patterns.txt */
// op_addr_wdata_expect_mask in hex. op 1 write, 2 read (wdata 1 raster, 2 raster bit 8,
// 3 pen line, 4 pen x, else expect), 3 wait line {addr,wdata}, 4 pen pulse, 5 pin, 6 idle
05_00_00_01_01
02_1A_00_F0_FF
02_20_00_F0_FF
06_00_00_FF_FF
01_20_05_00_00
02_20_00_F5_FF
05_01_00_05_0F
01_21_0C_00_00
02_21_00_FC_FF
05_02_00_0C_0F
01_1A_06_00_00
02_1A_00_F6_FF
02_3F_00_FF_FF
03_00_03_00_00
02_12_01_00_FF
02_11_02_00_80
01_12_05_00_00
01_1A_01_00_00
03_00_05_00_00
05_00_00_00_01
02_19_00_F1_FF
01_19_01_00_00
05_00_00_01_01
02_19_00_70_FF
01_1A_00_00_00
01_12_0A_00_00
03_00_0A_00_00
05_00_00_01_01
02_19_00_71_FF
01_1A_01_00_00
05_00_00_00_01
01_19_01_00_00
05_00_00_01_01
04_00_00_00_00
02_14_03_00_FF
02_13_04_00_FF
02_19_00_78_FF
03_00_14_00_00
04_00_00_00_00
02_14_03_00_FF
01_19_08_00_00
02_19_00_70_FF
03_01_04_00_00
02_12_01_00_FF
02_11_02_00_80
03_00_02_00_00
04_00_00_00_00
02_14_03_00_FF
02_13_04_00_FF
00_00_00_00_00

/* build.f */
design/vic_pkg.sv
design/phase_gen.sv
design/raster_timer.sv
design/cpu_regs.sv
design/vic_top.sv
tests/tb_vic_top.sv

/* Makefile */
# Verilator build and run for the video chip bus subsystem

VERILATOR ?= verilator
TOP       ?= tb_vic_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the run prints the pass line
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
